// File: uartLink_macros.svh
`ifndef uartLinkMacrosSvh
`define uartLinkMacrosSvh

////////////////////////////////////////////////////////////////////////////
// serial frame format
////////////////////////////////////////////////////////////////////////////

`define uartDataBits		8		// data bits per frame
`define uartSbTick			16		// ticks in the stop bit, 16 for one stop bit

////////////////////////////////////////////////////////////////////////////
// fifo sizing
////////////////////////////////////////////////////////////////////////////

`define uartFifoDepth		16		// entries per fifo
`define uartFifoAddrLen		4		// log2 of depth

////////////////////////////////////////////////////////////////////////////
// baud rate
////////////////////////////////////////////////////////////////////////////

// clock cycles per 16x oversampling tick
// one bit then lasts 16 * uartClksPerTick cycles
`define uartClksPerTick		4

`endif

// File: uartPkg.sv
`include "uartLink_macros.svh"
`default_nettype none

package uartPkg;

	// receiver fsm
	typedef enum logic [1:0] {
		rxIdle  = 2'b00,	// waiting for falling edge
		rxStart = 2'b01,	// counting to start bit middle
		rxData  = 2'b10,	// sampling data bits
		rxStop  = 2'b11		// stop bit
	} rxState_t;

	// transmitter fsm, same layout as the receiver
	typedef enum logic [1:0] {
		txIdle  = 2'b00,	// line high, waiting on fifo
		txStart = 2'b01,	// driving start bit
		txData  = 2'b10,	// shifting data out
		txStop  = 2'b11		// driving stop bit
	} txState_t;

	// one received frame as stored in the rx fifo
	typedef struct packed {
		logic [`uartDataBits-1:0] data;	// received byte
		logic frameErr;					// stop bit sampled low
	} rxWord_t;

endpackage

`default_nettype wire

// File: uartFifoIf.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

// push/pop channel of one fifo
interface uartFifoIf #(
	parameter type payload_t = logic [`uartDataBits-1:0]
);

	logic push;				// one-cycle write strobe
	payload_t pushData;
	logic pop;				// one-cycle read strobe
	payload_t popData;		// oldest entry, valid while !empty
	logic empty;
	logic full;

	modport producer (
		output push, pushData,
		input full
	);

	modport consumer (
		output pop,
		input popData, empty
	);

	modport fifo (
		input push, pushData, pop,
		output popData, empty, full
	);

endinterface

`default_nettype wire

// File: baudTickGen.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

// shared 16x oversampling strobe, keeps rx and tx on one grid
module baudTickGen (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	localparam int cntLen = (`uartClksPerTick > 1) ? $clog2(`uartClksPerTick) : 1;
	localparam logic [cntLen-1:0] cntLast = cntLen'(`uartClksPerTick - 1);

	logic [cntLen-1:0] cnt;		// free running divider

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			sTick <= 1'b0;
		end
		else if (cnt == cntLast)
		begin
			cnt <= '0;			// wrap
			sTick <= 1'b1;		// one cycle pulse on the wrap
		end
		else
		begin
			cnt <= cnt + 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: uartRec.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

module uartRec (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	uartFifoIf.producer wr,		// rx fifo write side
	output logic overrun		// sticky, frame lost on a full fifo
);

	// 16x oversampling, counter wide enough for longer stop bits too
	localparam int tickLen = ($clog2(`uartSbTick) > 4) ? $clog2(`uartSbTick) : 4;
	localparam int bitLen = $clog2(`uartDataBits);
	localparam logic [tickLen-1:0] midTick = tickLen'(7);		// half a bit
	localparam logic [tickLen-1:0] bitTick = tickLen'(15);		// one full bit
	localparam logic [tickLen-1:0] stopTick = tickLen'(`uartSbTick - 1);
	localparam logic [bitLen-1:0] lastBit = bitLen'(`uartDataBits - 1);

	uartPkg::rxState_t stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;			// tick counter
	logic [bitLen-1:0] nReg, nNext;				// data bit counter
	logic [`uartDataBits-1:0] bReg, bNext;		// shift register
	logic rxPrev;								// last rx, for edge detect
	logic rxDoneTick;							// frame complete
	uartPkg::rxWord_t word;

	////////////////////////////////////////////////////////////////////////////
	// state registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::rxIdle;
			sReg <= '0;
			nReg <= '0;
			rxPrev <= 1'b1;		// line idles high
			overrun <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			rxPrev <= rx;
			if (rxDoneTick && wr.full)
				overrun <= 1'b1;	// byte dropped, stays set
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			uartPkg::rxIdle:
				if (rxPrev && !rx)		// falling edge only, a held low line is ignored
				begin
					stateNext = uartPkg::rxStart;
					sNext = '0;
				end
			uartPkg::rxStart:
				if (sTick)
				begin
					if (sReg == midTick)
					begin
						// start bit middle, high here means a glitch
						stateNext = rx ? uartPkg::rxIdle : uartPkg::rxData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxData:
				if (sTick)
				begin
					if (sReg == bitTick)
					begin
						sNext = '0;
						bNext = {rx, bReg[`uartDataBits-1:1]};	// lsb arrives first
						if (nReg == lastBit)
							stateNext = uartPkg::rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStop:
				if (sTick)
				begin
					if (sReg == stopTick)
					begin
						stateNext = uartPkg::rxIdle;
						rxDoneTick = 1'b1;		// rx sampled here for frameErr
					end
					else
						sNext = sReg + 1'b1;
				end
		endcase
	end

	// byte plus stop bit check, pushed in the done cycle
	assign word = '{data: bReg, frameErr: ~rx};
	assign wr.pushData = word;
	assign wr.push = rxDoneTick & ~wr.full;

endmodule

`default_nettype wire

// File: uartFifo.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

// first-word-fall-through circular buffer
module uartFifo #(
	parameter type payload_t = logic [`uartDataBits-1:0]
) (
	input  logic clk,
	input  logic reset,
	uartFifoIf.fifo bus
);

	localparam int addrLen = `uartFifoAddrLen;
	localparam logic [addrLen:0] depth = (addrLen + 1)'(`uartFifoDepth);

	payload_t mem [`uartFifoDepth];
	logic [addrLen-1:0] wrPtr;
	logic [addrLen-1:0] rdPtr;
	logic [addrLen:0] count;	// occupancy, one bit wider than the pointers
	logic doPush;
	logic doPop;

	assign bus.empty = (count == '0);
	assign bus.full = (count == depth);

	// a pop on a full fifo frees the slot for a push in the same cycle
	assign doPop = bus.pop & ~bus.empty;
	assign doPush = bus.push & (~bus.full | doPop);

	// oldest entry falls through
	assign bus.popData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= bus.pushData;
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers and count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;		// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;		// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uartTrans.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

module uartTrans (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	uartFifoIf.consumer rd,		// tx fifo read side
	output logic tx
);

	localparam int tickLen = ($clog2(`uartSbTick) > 4) ? $clog2(`uartSbTick) : 4;
	localparam int bitLen = $clog2(`uartDataBits);
	localparam logic [tickLen-1:0] bitTick = tickLen'(15);
	localparam logic [tickLen-1:0] stopTick = tickLen'(`uartSbTick - 1);
	localparam logic [bitLen-1:0] lastBit = bitLen'(`uartDataBits - 1);

	uartPkg::txState_t stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;
	logic [bitLen-1:0] nReg, nNext;
	logic [`uartDataBits-1:0] bReg, bNext;		// byte being shifted out
	logic txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg <= '0;
			nReg <= '0;
			tx <= 1'b1;			// idle line
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			tx <= txNext;		// registered, no glitches on the pin
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////////////
	// next state and line level
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = 1'b1;
		rd.pop = 1'b0;
		case (stateReg)
			uartPkg::txIdle:
				if (!rd.empty)
				begin
					rd.pop = 1'b1;			// single strobe, state moves on next cycle
					bNext = rd.popData;
					sNext = '0;
					stateNext = uartPkg::txStart;
				end
			uartPkg::txStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == bitTick)
					begin
						stateNext = uartPkg::txData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txData:
			begin
				txNext = bReg[0];		// lsb first
				if (sTick)
				begin
					if (sReg == bitTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == lastBit)
							stateNext = uartPkg::txStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == stopTick)
						stateNext = uartPkg::txIdle;	// line already high
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// File: uartLink.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

module uartLink (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic txWrite,						// write strobe, no back-pressure
	input  logic [`uartDataBits-1:0] txData,
	input  logic rxRead,						// read strobe, pops the shown byte
	output logic tx,
	output logic [`uartDataBits-1:0] rxData,
	output logic rxFrameErr,
	output logic rxEmpty,
	output logic txFull,
	output logic rxOverrun
);

	logic sTick;

	uartFifoIf #(.payload_t(uartPkg::rxWord_t)) rxFifoBus ();
	uartFifoIf #(.payload_t(logic [`uartDataBits-1:0])) txFifoBus ();

	////////////////////////////////////////////////////////////////////////////
	// processor side strobes and status
	////////////////////////////////////////////////////////////////////////////

	assign rxFifoBus.pop = rxRead;
	assign rxData = rxFifoBus.popData.data;
	assign rxFrameErr = rxFifoBus.popData.frameErr;
	assign rxEmpty = rxFifoBus.empty;

	assign txFifoBus.push = txWrite;		// dropped by the fifo when full
	assign txFifoBus.pushData = txData;
	assign txFull = txFifoBus.full;

	////////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////////

	baudTickGen tickGen (.clk(clk), .reset(reset), .sTick(sTick));

	uartRec rec (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.wr(rxFifoBus.producer),
		.overrun(rxOverrun)
	);

	uartFifo #(.payload_t(uartPkg::rxWord_t)) rxFifo (
		.clk(clk), .reset(reset), .bus(rxFifoBus.fifo)
	);

	uartFifo #(.payload_t(logic [`uartDataBits-1:0])) txFifo (
		.clk(clk), .reset(reset), .bus(txFifoBus.fifo)
	);

	uartTrans trans (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rd(txFifoBus.consumer),
		.tx(tx)
	);

endmodule

`default_nettype wire

// File: uartLink_assert.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

// properties shared by the receiver and transmitter binds
module uartLink_assert (
	input wire logic clk,
	input wire logic reset,
	input wire logic sTick,
	input wire logic doneTick,		// receiver frame done
	input wire logic inStop,		// receiver in stop state
	input wire logic push,			// rx fifo write strobe
	input wire logic full,			// rx fifo full flag
	input wire logic overrun,		// receiver sticky overrun flag
	input wire logic idle,			// transmitter in idle state
	input wire logic line			// transmitter tx pin
);

	// two done strobes lie at least nine bit times apart
	localparam int minFrameClks = 9 * 16 * `uartClksPerTick;

	int sinceDone;		// cycles since the last done strobe, saturates

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sinceDone <= minFrameClks;
		else if (doneTick)
			sinceDone <= 0;
		else if (sinceDone < minFrameClks)
			sinceDone <= sinceDone + 1;
	end

	// done only on a tick out of the stop bit, a full frame after the last one
	doneOnStopTick: assert property (@(posedge clk) disable iff (reset)
		doneTick |-> (sTick && inStop && sinceDone >= minFrameClks))
		else $error("receiver done strobe outside a stop bit tick or too early");

	// idle line must be high
	txIdleHigh: assert property (@(posedge clk) disable iff (reset)
		idle |-> line)
		else $error("tx low while transmitter idle");

	// frame on a full fifo is dropped and flags overrun
	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		(doneTick && full) |=> (overrun && !$past(push)))
		else $error("rx fifo pushed while full or overrun not set");

endmodule

bind uartRec uartLink_assert recProps (
	.clk(clk), .reset(reset), .sTick(sTick),
	.doneTick(rxDoneTick), .inStop(stateReg == uartPkg::rxStop),
	.push(wr.push), .full(wr.full), .overrun(overrun),
	.idle(1'b0), .line(1'b1)				// tx side unused here
);

bind uartTrans uartLink_assert transProps (
	.clk(clk), .reset(reset), .sTick(sTick),
	.doneTick(1'b0), .inStop(1'b0),
	.push(1'b0), .full(1'b0), .overrun(1'b0),
	.idle(stateReg == uartPkg::txIdle), .line(tx)
);

`default_nettype wire

// File: uartLink_checker.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

// watches the DUT pins, decodes tx and compares rx reads
module uartLink_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic tx,
	input wire logic rxRead, rxEmpty, rxFrameErr, rxOverrun,
	input wire logic [`uartDataBits-1:0] rxData,
	input wire logic txWrite, txFull,
	input wire logic [`uartDataBits-1:0] txData,
	input wire logic expStb,						// push one rx expectation
	input wire logic [`uartDataBits-1:0] expByte,
	input wire logic expErr,
	input wire logic expOverrun,					// level expected on rxOverrun
	input wire logic endRun,						// final leftover check
	output int errors,
	output int checks,
	output int txPending							// frames still to see on tx
);

	localparam int bitClks = 16 * `uartClksPerTick;
	localparam int halfBit = bitClks / 2;

	logic [`uartDataBits:0] rxExp [$];		// {byte, frameErr}
	logic [`uartDataBits-1:0] txExp [$];
	int errCount = 0;
	int checkCount = 0;
	int pending = 0;
	logic resetChecked = 1'b0;
	logic emptyDue = 1'b0;					// last expected read done, rxEmpty next
	logic txPrev = 1'b1;
	logic txBusy = 1'b0;					// inside a tx frame
	int txCnt = 0;
	logic [`uartDataBits-1:0] txBits = '0;

	assign errors = errCount;
	assign checks = checkCount;
	assign txPending = pending;

	task automatic reportMismatch(input string msg);
		errCount++;
		$display("[FAIL] %0t %s", $time, msg);
	endtask

	task automatic compareRead();
		logic [`uartDataBits:0] want;
		if (rxExp.size() == 0)
		begin
			errCount++;
			$display("rxRead strobe at %0t with no received byte expected", $time);
		end
		else
		begin
			want = rxExp.pop_front();
			checkCount++;
			if (rxEmpty)
				reportMismatch($sformatf("rxEmpty high, expected byte %h", want[`uartDataBits:1]));
			else if (rxData !== want[`uartDataBits:1] || rxFrameErr !== want[0])
				reportMismatch($sformatf("rx got %h err %b, expected %h err %b",
					rxData, rxFrameErr, want[`uartDataBits:1], want[0]));
			if (rxOverrun !== expOverrun)
				reportMismatch($sformatf("rxOverrun %b, expected %b", rxOverrun, expOverrun));
			if (rxExp.size() == 0)
				emptyDue = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tx frame decoder, samples at bit centres
	////////////////////////////////////////////////////////////////////////////

	task automatic decodeTx();
		logic [`uartDataBits-1:0] want;
		int k;
		if (!txBusy)
		begin
			if (txPrev && !tx)		// start edge
			begin
				txBusy = 1'b1;
				txCnt = 0;
			end
		end
		else
		begin
			txCnt++;
			k = (txCnt - halfBit) / bitClks;
			if (txCnt == halfBit && tx !== 1'b0)
			begin
				reportMismatch("tx start bit not low at its centre");
				txBusy = 1'b0;		// resync on next edge
			end
			else if (txCnt > halfBit && (txCnt - halfBit) % bitClks == 0)
			begin
				if (k <= `uartDataBits)
					txBits[k-1] = tx;		// lsb first
				else
				begin
					txBusy = 1'b0;
					checkCount++;
					if (tx !== 1'b1)
						reportMismatch("tx stop bit low");
					if (txExp.size() == 0)
					begin
						errCount++;
						$display("frame %h on tx at %0t with nothing written", txBits, $time);
					end
					else
					begin
						want = txExp.pop_front();
						if (txBits !== want)
							reportMismatch($sformatf("tx frame %h, expected %h", txBits, want));
					end
				end
			end
		end
		txPrev = tx;
	endtask

	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (!resetChecked)		// first cycle out of reset
			begin
				checkCount++;
				if (tx !== 1'b1 || rxEmpty !== 1'b1 || txFull !== 1'b0 || rxOverrun !== 1'b0)
					reportMismatch($sformatf("reset state tx %b rxEmpty %b txFull %b rxOverrun %b",
						tx, rxEmpty, txFull, rxOverrun));
				resetChecked = 1'b1;
			end
			if (expStb)
				rxExp.push_back({expByte, expErr});
			if (txWrite && !txFull)
				txExp.push_back(txData);	// a write on a full fifo is lost
			if (emptyDue)
			begin
				checkCount++;
				if (rxEmpty !== 1'b1)
					reportMismatch("rxEmpty low after the last expected read");
				emptyDue = 1'b0;
			end
			if (rxRead)
				compareRead();
			decodeTx();
			if (endRun && (rxExp.size() != 0 || txExp.size() != 0))
			begin
				errCount++;
				$display("%0d rx and %0d tx bytes were never seen", rxExp.size(), txExp.size());
			end
			pending = txExp.size();
		end
	end

endmodule

`default_nettype wire

// File: uartLink_tb.sv
`timescale 1ns/1ps
`include "uartLink_macros.svh"
`default_nettype none

module uartLink_tb;

	localparam int rxLen = 6;
	localparam int txLen = 6;
	localparam int rxOvfFrames = 3 * rxLen;		// 18 frames, two past the fifo depth
	localparam int txOvfWrites = `uartFifoDepth + 1;	// one past the fifo depth, all while busy
	localparam int bitClks = 16 * `uartClksPerTick;
	// every frame sent or written, 640 cycles each, doubled for gaps
	localparam int cycleLimit = (rxLen + rxOvfFrames + txLen + txOvfWrites) * 640 * 2 + 1000;

	// receive table, byte and the stop bit level driven on rx
	localparam logic [7:0] rxByteTab [rxLen] = '{8'h55, 8'hA3, 8'h00, 8'hFF, 8'h3C, 8'h81};
	localparam logic rxStopTab [rxLen] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
	// transmit table
	localparam logic [7:0] txTab [txLen] = '{8'h5A, 8'h01, 8'h80, 8'hC3, 8'h7E, 8'hF0};

	logic clk = 1'b0;
	logic reset;
	logic rx, txWrite, rxRead;
	logic [`uartDataBits-1:0] txData;
	logic tx, rxFrameErr, rxEmpty, txFull, rxOverrun;
	logic [`uartDataBits-1:0] rxData;
	logic expStb, expErr, expOverrun, endRun;
	logic [`uartDataBits-1:0] expByte;
	int errors, checks, txPending;
	int cycles = 0;

	always #50 clk = ~clk;		// 100 ns period

	uartLink DUT (
		.clk(clk), .reset(reset), .rx(rx),
		.txWrite(txWrite), .txData(txData), .rxRead(rxRead),
		.tx(tx), .rxData(rxData), .rxFrameErr(rxFrameErr),
		.rxEmpty(rxEmpty), .txFull(txFull), .rxOverrun(rxOverrun)
	);

	uartLink_checker chk (
		.clk(clk), .reset(reset), .tx(tx),
		.rxRead(rxRead), .rxEmpty(rxEmpty), .rxFrameErr(rxFrameErr), .rxOverrun(rxOverrun),
		.rxData(rxData), .txWrite(txWrite), .txFull(txFull), .txData(txData),
		.expStb(expStb), .expByte(expByte), .expErr(expErr), .expOverrun(expOverrun),
		.endRun(endRun), .errors(errors), .checks(checks), .txPending(txPending)
	);

	////////////////////////////////////////////////////////////////////////////
	// drivers, all called and returning at posedge + 1 ns
	////////////////////////////////////////////////////////////////////////////

	// 8N1 frame on rx, then a random idle gap
	task automatic sendFrame(input logic [7:0] value, input logic stopBit);
		logic [9:0] frame;
		int gap;
		frame = {stopBit, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rx = frame[i];
			repeat (bitClks) @(posedge clk);
			#1;
		end
		rx = 1'b1;
		gap = 16 + int'($urandom % 48);
		repeat (gap) @(posedge clk);
		#1;
	endtask

	task automatic expectRx(input logic [7:0] value, input logic err);
		expByte = value;
		expErr = err;
		expStb = 1'b1;
		@(posedge clk);
		#1;
		expStb = 1'b0;
	endtask

	task automatic readRx(input int count);
		for (int i = 0; i < count; i++)
		begin
			rxRead = 1'b1;
			@(posedge clk);
			#1;
			rxRead = 1'b0;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic waitTxDrained();
		while (txPending != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	initial
	begin
		logic [7:0] b;
		void'($urandom(26));
		rx = 1'b1;
		txWrite = 1'b0;
		txData = '0;
		rxRead = 1'b0;
		expStb = 1'b0;
		expByte = '0;
		expErr = 1'b0;
		expOverrun = 1'b0;
		endRun = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		// ordered receive, low stop entries give frameErr
		for (int i = 0; i < rxLen; i++)
		begin
			sendFrame(rxByteTab[i], rxStopTab[i]);
			expectRx(rxByteTab[i], !rxStopTab[i]);
		end
		readRx(rxLen);
		// receive overflow, nothing read until all frames are in
		for (int i = 0; i < rxOvfFrames; i++)
		begin
			b = rxByteTab[i % rxLen] ^ 8'(i);
			sendFrame(b, rxStopTab[i % rxLen]);
			if (i < `uartFifoDepth)
				expectRx(b, !rxStopTab[i % rxLen]);
		end
		expOverrun = 1'b1;
		readRx(`uartFifoDepth);
		// transmit in order, short gaps while the first frame is going out
		for (int i = 0; i < txLen; i++)
		begin
			txWrite = 1'b1;
			txData = txTab[i];
			@(posedge clk);
			#1;
			txWrite = 1'b0;
			repeat (3) @(posedge clk);
			#1;
		end
		waitTxDrained();
		// back to back writes, the fifo fills behind the busy transmitter
		for (int i = 0; i < txOvfWrites; i++)
		begin
			txWrite = 1'b1;
			txData = txTab[i % txLen] + 8'(i);
			@(posedge clk);
			#1;
		end
		txWrite = 1'b0;
		waitTxDrained();
		endRun = 1'b1;
		@(posedge clk);
		#1;
		endRun = 1'b0;
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: uartLink.f
+incdir+.
uartPkg.sv
uartFifoIf.sv
baudTickGen.sv
uartRec.sv
uartFifo.sv
uartTrans.sv
uartLink.sv
uartLink_assert.sv
uartLink_checker.sv
uartLink_tb.sv

// File: run.sh
#!/bin/sh
# build and run the uartLink testbench with Verilator

verilator --binary --timing --assert -f uartLink.f --top-module uartLink_tb -o uartLinkSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/uartLinkSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0
